// ==== rom_pkg.sv ====
package rom_pkg;

// SDRAM read port
localparam int SDRAM_AW = 22;
localparam int DATA_W   = 16;

// APB slave bus
localparam int APB_AW = 8;
localparam int APB_DW = 32;

// Register map, byte addresses on the APB bus
localparam logic [APB_AW-1:0] REG_CTRL        = 8'h00;
localparam logic [APB_AW-1:0] REG_STATUS      = 8'h04;
// Slot i offset lives at REG_OFFSET_BASE + 4*i
localparam logic [APB_AW-1:0] REG_OFFSET_BASE = 8'h10;

// Control register bits
localparam int CTRL_ENABLE = 0;
// Self-clearing, always reads back as zero
localparam int CTRL_FLUSH  = 1;

endpackage

// ==== rom_cfg_regs.sv ====
`timescale 1ns/1ps

module rom_cfg_regs #(
    parameter NSLOTS = 4
) (
    input                                          clk,
    input                                          rst,
    // APB slave
    input                                          psel,
    input                                          penable,
    input                                          pwrite,
    input        [rom_pkg::APB_AW-1:0]             paddr,
    input        [rom_pkg::APB_DW-1:0]             pwdata,
    output logic [rom_pkg::APB_DW-1:0]             prdata,
    output                                         pready,
    output                                         pslverr,
    // Pending misses, one bit per slot
    input        [NSLOTS-1:0]                      miss_pending,
    // Configuration
    output       [NSLOTS*rom_pkg::SDRAM_AW-1:0]    slot_offset,
    output logic                                   enable,
    output logic                                   flush
);

localparam int AW    = rom_pkg::SDRAM_AW;
localparam int BW    = rom_pkg::APB_AW;
localparam int SEL_W = NSLOTS > 1 ? $clog2(NSLOTS) : 1;

logic [AW-1:0]    offset_q [NSLOTS];
logic             access;
logic             wr;
logic             ctrl_hit;
logic             status_hit;
logic             ofs_hit;
logic [SEL_W-1:0] ofs_sel;

// Access phase of a transfer, no wait states
assign access     = psel && penable;
assign wr         = access && pwrite;
assign pready     = 1'b1;

assign ctrl_hit   = paddr == rom_pkg::REG_CTRL;
assign status_hit = paddr == rom_pkg::REG_STATUS;

// Offset registers are word aligned, four bytes apart
always_comb begin
    ofs_hit = 1'b0;
    ofs_sel = '0;
    for (int i = 0; i < NSLOTS; i++) begin
        if (paddr == BW'(rom_pkg::REG_OFFSET_BASE + 4 * i)) begin
            ofs_hit = 1'b1;
            ofs_sel = SEL_W'(i);
        end
    end
end

assign pslverr = access && !(ctrl_hit || status_hit || ofs_hit);

// Read mux
always_comb begin
    prdata = '0;
    if (ctrl_hit) begin
        prdata[rom_pkg::CTRL_ENABLE] = enable;
    end else if (status_hit) begin
        prdata[NSLOTS-1:0] = miss_pending;
    end else if (ofs_hit) begin
        prdata[AW-1:0] = offset_q[ofs_sel];
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        enable <= 1'b0;
        flush  <= 1'b0;
        for (int i = 0; i < NSLOTS; i++) begin
            offset_q[i] <= '0;
        end
    end else begin
        // Single cycle pulse, the access phase lasts one clock
        flush <= wr && ctrl_hit && pwdata[rom_pkg::CTRL_FLUSH];
        if (wr && ctrl_hit) begin
            enable <= pwdata[rom_pkg::CTRL_ENABLE];
        end
        if (wr && ofs_hit) begin
            offset_q[ofs_sel] <= pwdata[AW-1:0];
        end
    end
end

// Flatten for the arbiter
genvar g;
generate
    for (g = 0; g < NSLOTS; g++) begin : g_ofs
        assign slot_offset[g*AW +: AW] = offset_q[g];
    end
endgenerate

endmodule

// ==== rom_slot.sv ====
`timescale 1ns/1ps

module rom_slot #(
    parameter SLOT_AW     = 12,
    parameter CACHE_LINES = 4
) (
    input                              clk,
    input                              rst,
    // Requester side
    input                              cs,
    input        [SLOT_AW-1:0]         addr,
    output       [rom_pkg::DATA_W-1:0] dout,
    output                             ok,
    // Cache control
    input                              flush,
    // Towards the arbiter
    output logic                       miss_req,
    output logic [SLOT_AW-1:0]         miss_addr,
    input                              fill_valid,
    input        [rom_pkg::DATA_W-1:0] fill_data
);

localparam int IDX_W = $clog2(CACHE_LINES);
localparam int TAG_W = SLOT_AW - IDX_W;

logic [TAG_W-1:0]           tag_mem  [CACHE_LINES];
logic [rom_pkg::DATA_W-1:0] data_mem [CACHE_LINES];
logic [CACHE_LINES-1:0]     valid;

logic [IDX_W-1:0] idx;
logic [TAG_W-1:0] tag;
logic [IDX_W-1:0] fill_idx;
logic [TAG_W-1:0] fill_tag;
logic             hit;
logic             start_miss;

// Direct mapped, low bits pick the line
assign idx      = addr[IDX_W-1:0];
assign tag      = addr[SLOT_AW-1:IDX_W];
assign fill_idx = miss_addr[IDX_W-1:0];
assign fill_tag = miss_addr[SLOT_AW-1:IDX_W];

assign hit  = valid[idx] && (tag_mem[idx] == tag);
assign ok   = cs && hit;
assign dout = data_mem[idx];

// New miss only when nothing is outstanding and no flush or fill this cycle
assign start_miss = cs && !hit && !miss_req && !flush && !fill_valid;

// Line storage
always_ff @(posedge clk) begin
    if (fill_valid) begin
        tag_mem[fill_idx]  <= fill_tag;
        data_mem[fill_idx] <= fill_data;
    end
end

// A fill arriving with a flush still lands
always_ff @(posedge clk) begin
    if (rst) begin
        valid <= '0;
    end else begin
        if (flush) begin
            valid <= '0;
        end
        if (fill_valid) begin
            valid[fill_idx] <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        miss_req <= 1'b0;
    end else if (fill_valid || flush) begin
        miss_req <= 1'b0;
    end else if (start_miss) begin
        miss_req <= 1'b1;
    end
end

// Held until the line is filled
always_ff @(posedge clk) begin
    if (start_miss) begin
        miss_addr <= addr;
    end
end

endmodule

// ==== rom_slot_arbiter.sv ====
`timescale 1ns/1ps

module rom_slot_arbiter #(
    parameter NSLOTS  = 4,
    parameter SLOT_AW = 12
) (
    input                                       clk,
    input                                       rst,
    input                                       enable,
    input        [NSLOTS*rom_pkg::SDRAM_AW-1:0] slot_offset,
    // Slot side
    input        [NSLOTS-1:0]                   miss_req,
    input        [NSLOTS*SLOT_AW-1:0]           miss_addr,
    output logic [NSLOTS-1:0]                   fill_valid,
    output logic [rom_pkg::DATA_W-1:0]          fill_data,
    // SDRAM read port
    output logic                                sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0]        sdram_addr,
    input                                       sdram_ack,
    input                                       data_rdy,
    input        [rom_pkg::DATA_W-1:0]          data_read
);

localparam int AW    = rom_pkg::SDRAM_AW;
localparam int SEL_W = NSLOTS > 1 ? $clog2(NSLOTS) : 1;

typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    WAIT_DATA
} state_t;

state_t           state;
logic [NSLOTS-1:0] pending;
logic             any_pend;
logic [SEL_W-1:0] pick;
logic [SEL_W-1:0] owner;
logic [AW-1:0]    pick_offset;
logic [SLOT_AW-1:0] pick_addr;
logic             grant;
logic             fill_now;

// The slot being filled still shows its request this cycle
assign pending  = miss_req & ~fill_valid;
assign any_pend = |pending;

// Lowest index wins
always_comb begin
    pick = '0;
    for (int i = NSLOTS - 1; i >= 0; i--) begin
        if (pending[i]) begin
            pick = SEL_W'(i);
        end
    end
end

assign pick_offset = slot_offset[pick*AW +: AW];
assign pick_addr   = miss_addr[pick*SLOT_AW +: SLOT_AW];

assign grant    = (state == IDLE) && enable && any_pend;
assign fill_now = (state == WAIT_DATA) && data_rdy;

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= IDLE;
        sdram_req  <= 1'b0;
        fill_valid <= '0;
        owner      <= '0;
    end else begin
        fill_valid <= '0;
        case (state)
            IDLE: begin
                if (grant) begin
                    owner     <= pick;
                    sdram_req <= 1'b1;
                    state     <= WAIT_ACK;
                end
            end
            // Request and address stay put until accepted
            WAIT_ACK: begin
                if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= WAIT_DATA;
                end
            end
            // Enable is not checked here, the read always completes
            WAIT_DATA: begin
                if (data_rdy) begin
                    fill_valid[owner] <= 1'b1;
                    state             <= IDLE;
                end
            end
            default: begin
                state <= IDLE;
            end
        endcase
    end
end

// Address and data registers
always_ff @(posedge clk) begin
    if (grant) begin
        sdram_addr <= pick_offset + AW'(pick_addr);
    end
    if (fill_now) begin
        fill_data <= data_read;
    end
end

endmodule

// ==== rom_fetch.sv ====
`timescale 1ns/1ps

module rom_fetch #(
    parameter NSLOTS      = 4,
    parameter SLOT_AW     = 12,
    parameter CACHE_LINES = 4
) (
    input                                  clk,
    input                                  rst,
    // APB configuration port
    input                                  psel,
    input                                  penable,
    input                                  pwrite,
    input  [rom_pkg::APB_AW-1:0]           paddr,
    input  [rom_pkg::APB_DW-1:0]           pwdata,
    output [rom_pkg::APB_DW-1:0]           prdata,
    output                                 pready,
    output                                 pslverr,
    // Requesters, packed per slot
    input  [NSLOTS-1:0]                    slot_cs,
    input  [NSLOTS*SLOT_AW-1:0]            slot_addr,
    output [NSLOTS*rom_pkg::DATA_W-1:0]    slot_dout,
    output [NSLOTS-1:0]                    slot_ok,
    // SDRAM read port
    output                                 sdram_req,
    output [rom_pkg::SDRAM_AW-1:0]         sdram_addr,
    input                                  sdram_ack,
    input                                  data_rdy,
    input  [rom_pkg::DATA_W-1:0]           data_read
);

localparam int DW = rom_pkg::DATA_W;

wire [NSLOTS*rom_pkg::SDRAM_AW-1:0] slot_offset;
wire                                enable;
wire                                flush;
wire [NSLOTS-1:0]                   miss_req;
wire [NSLOTS*SLOT_AW-1:0]           miss_addr;
wire [NSLOTS-1:0]                   fill_valid;
wire [DW-1:0]                       fill_data;

rom_cfg_regs #(
    .NSLOTS       ( NSLOTS       )
) u_regs (
    .clk          ( clk          ),
    .rst          ( rst          ),
    .psel         ( psel         ),
    .penable      ( penable      ),
    .pwrite       ( pwrite       ),
    .paddr        ( paddr        ),
    .pwdata       ( pwdata       ),
    .prdata       ( prdata       ),
    .pready       ( pready       ),
    .pslverr      ( pslverr      ),
    .miss_pending ( miss_req     ),
    .slot_offset  ( slot_offset  ),
    .enable       ( enable       ),
    .flush        ( flush        )
);

genvar g;
generate
    for (g = 0; g < NSLOTS; g++) begin : g_slot
        rom_slot #(
            .SLOT_AW     ( SLOT_AW                           ),
            .CACHE_LINES ( CACHE_LINES                       )
        ) u_slot (
            .clk         ( clk                               ),
            .rst         ( rst                               ),
            .cs          ( slot_cs[g]                        ),
            .addr        ( slot_addr[g*SLOT_AW +: SLOT_AW]   ),
            .dout        ( slot_dout[g*DW +: DW]             ),
            .ok          ( slot_ok[g]                        ),
            .flush       ( flush                             ),
            .miss_req    ( miss_req[g]                       ),
            .miss_addr   ( miss_addr[g*SLOT_AW +: SLOT_AW]   ),
            .fill_valid  ( fill_valid[g]                     ),
            .fill_data   ( fill_data                         )
        );
    end
endgenerate

rom_slot_arbiter #(
    .NSLOTS      ( NSLOTS      ),
    .SLOT_AW     ( SLOT_AW     )
) u_arb (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .enable      ( enable      ),
    .slot_offset ( slot_offset ),
    .miss_req    ( miss_req    ),
    .miss_addr   ( miss_addr   ),
    .fill_valid  ( fill_valid  ),
    .fill_data   ( fill_data   ),
    .sdram_req   ( sdram_req   ),
    .sdram_addr  ( sdram_addr  ),
    .sdram_ack   ( sdram_ack   ),
    .data_rdy    ( data_rdy    ),
    .data_read   ( data_read   )
);

endmodule

// ==== tb_ref.svh ====
// Expected ROM word for an SDRAM word address
// Low half of the address, high bits folded in with an xor
function automatic logic [rom_pkg::DATA_W-1:0] ref_word(
    input logic [rom_pkg::SDRAM_AW-1:0] a
);
    return a[rom_pkg::DATA_W-1:0] ^
           {{(2 * rom_pkg::DATA_W - rom_pkg::SDRAM_AW){1'b0}},
            a[rom_pkg::SDRAM_AW-1:rom_pkg::DATA_W]};
endfunction

// ==== tb_sdram_model.sv ====
`timescale 1ns/1ps

module tb_sdram_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input                                clk,
    input                                rst,
    input                                sdram_req,
    input        [rom_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic                         sdram_ack,
    output logic                         data_rdy,
    output logic [rom_pkg::DATA_W-1:0]   data_read
);

`include "tb_ref.svh"

integer                       seed;
int                           cnt;
logic                         busy;
logic [rom_pkg::SDRAM_AW-1:0] addr_q;

// One read in flight
// Ack 0 to 3 cycles after the request and data 2 to 5 cycles after the ack
always @(posedge clk) begin
    sdram_ack <= 1'b0;
    data_rdy  <= 1'b0;
    if (rst) begin
        seed = SEED;
        cnt  = 0;
        busy      <= 1'b0;
        data_read <= '0;
    end else if (!busy) begin
        if (sdram_req) begin
            if (cnt == 0) begin
                sdram_ack <= 1'b1;
                addr_q    <= sdram_addr;
                busy      <= 1'b1;
                cnt = 1 + int'($unsigned($random(seed)) % 4);
            end else begin
                cnt = cnt - 1;
            end
        end
    end else if (cnt == 0) begin
        data_rdy  <= 1'b1;
        data_read <= ref_word(addr_q);
        busy      <= 1'b0;
        // Next acknowledge delay
        cnt = int'($unsigned($random(seed)) % 4);
    end else begin
        cnt = cnt - 1;
    end
end

endmodule

// ==== tb_rom_checker.sv ====
`timescale 1ns/1ps

module tb_rom_checker #(
    parameter NSLOTS  = 4,
    parameter SLOT_AW = 12
) (
    input                                  clk,
    input                                  rst,
    input                                  psel,
    input                                  penable,
    input                                  pwrite,
    input  [rom_pkg::APB_AW-1:0]           paddr,
    input  [rom_pkg::APB_DW-1:0]           pwdata,
    input  [NSLOTS-1:0]                    slot_cs,
    input  [NSLOTS*SLOT_AW-1:0]            slot_addr,
    input  [NSLOTS*rom_pkg::DATA_W-1:0]    slot_dout,
    input  [NSLOTS-1:0]                    slot_ok,
    output int                             errors
);

`include "tb_ref.svh"

localparam int AW = rom_pkg::SDRAM_AW;
localparam int DW = rom_pkg::DATA_W;

logic [AW-1:0] offs [NSLOTS];

always @(posedge clk) begin
    logic [AW-1:0] a;
    logic [DW-1:0] exp;
    if (rst) begin
        errors = 0;
        for (int i = 0; i < NSLOTS; i++) begin
            offs[i] <= '0;
        end
    end else begin
        // Shadow copy of the offset registers
        if (psel && penable && pwrite) begin
            for (int i = 0; i < NSLOTS; i++) begin
                if (paddr == rom_pkg::REG_OFFSET_BASE + 8'(4 * i)) begin
                    offs[i] <= pwdata[AW-1:0];
                end
            end
        end
        for (int i = 0; i < NSLOTS; i++) begin
            if (slot_cs[i] && slot_ok[i]) begin
                a   = offs[i] + AW'(slot_addr[i*SLOT_AW +: SLOT_AW]);
                exp = ref_word(a);
                if (slot_dout[i*DW +: DW] !== exp) begin
                    $display("mismatch at %0t: slot %0d address %h read %h, expected %h",
                             $time, i, slot_addr[i*SLOT_AW +: SLOT_AW],
                             slot_dout[i*DW +: DW], exp);
                    errors = errors + 1;
                end
            end
        end
    end
end

endmodule

// ==== tb_rom_fetch.sv ====
`timescale 1ns/1ps

module tb_rom_fetch;

localparam int          NSLOTS  = 4;
localparam int          SLOT_AW = 12;
localparam int          AW      = rom_pkg::SDRAM_AW;
localparam int          DW      = rom_pkg::DATA_W;
localparam logic [31:0] SEED    = 32'ha48990f9;
localparam int          TIMEOUT = 200;

logic                        clk = 1'b0;
logic                        rst;
logic                        psel;
logic                        penable;
logic                        pwrite;
logic [rom_pkg::APB_AW-1:0]  paddr;
logic [rom_pkg::APB_DW-1:0]  pwdata;
wire  [rom_pkg::APB_DW-1:0]  prdata;
wire                         pready;
wire                         pslverr;
logic [NSLOTS-1:0]           slot_cs;
logic [NSLOTS*SLOT_AW-1:0]   slot_addr;
wire  [NSLOTS*DW-1:0]        slot_dout;
wire  [NSLOTS-1:0]           slot_ok;
wire                         sdram_req;
wire  [AW-1:0]               sdram_addr;
wire                         sdram_ack;
wire                         data_rdy;
wire  [DW-1:0]               data_read;

integer             seed;
int                 tb_errors;
int                 chk_errors;
int                 req_count;
logic [AW-1:0]      req_log [$];
logic [AW-1:0]      offs [NSLOTS];
logic [SLOT_AW-1:0] last_addr [NSLOTS];
logic [31:0]        rd;
logic               err;
logic [NSLOTS-1:0]  done;
int                 n;
int                 cnt;

always #5 clk = ~clk;

rom_fetch #(
    .NSLOTS      ( NSLOTS  ),
    .SLOT_AW     ( SLOT_AW ),
    .CACHE_LINES ( 4       )
) dut_i (
    .clk (clk), .rst (rst), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .pslverr (pslverr), .slot_cs (slot_cs), .slot_addr (slot_addr),
    .slot_dout (slot_dout), .slot_ok (slot_ok), .sdram_req (sdram_req),
    .sdram_addr (sdram_addr), .sdram_ack (sdram_ack), .data_rdy (data_rdy),
    .data_read (data_read)
);

tb_sdram_model #(.SEED(SEED)) sdram_i (
    .clk (clk), .rst (rst), .sdram_req (sdram_req), .sdram_addr (sdram_addr),
    .sdram_ack (sdram_ack), .data_rdy (data_rdy), .data_read (data_read)
);

tb_rom_checker #(.NSLOTS(NSLOTS), .SLOT_AW(SLOT_AW)) chk_i (
    .clk (clk), .rst (rst), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .slot_cs (slot_cs), .slot_addr (slot_addr),
    .slot_dout (slot_dout), .slot_ok (slot_ok), .errors (chk_errors)
);

// Log of accepted SDRAM reads in order of acceptance
always @(posedge clk) begin
    if (!rst && sdram_req && sdram_ack) begin
        req_count = req_count + 1;
        req_log.push_back(sdram_addr);
    end
end

task automatic apb_xfer(input logic wr_en, input logic [7:0] a, input logic [31:0] d,
                        output logic [31:0] rdata, output logic slverr);
    int k;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr_en;
    paddr   <= a;
    pwdata  <= d;
    @(posedge clk);
    penable <= 1'b1;
    k = 0;
    do begin
        @(posedge clk);
        k++;
    end while (!pready && k < TIMEOUT);
    if (!pready) begin
        $display("APB transfer to address %h timed out waiting for pready", a);
        tb_errors++;
    end
    rdata = prdata;
    slverr = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
    logic [31:0] unused_rd;
    logic        unused_err;
    apb_xfer(1'b1, a, d, unused_rd, unused_err);
endtask

task automatic check_read(input logic [7:0] a, input logic [31:0] exp);
    apb_xfer(1'b0, a, 32'h0, rd, err);
    if (rd !== exp || err) begin
        $display("mismatch at %0t: register %h read %h err %b, expected %h",
                 $time, a, rd, err, exp);
        tb_errors++;
    end
endtask

task automatic present(input int s, input logic [SLOT_AW-1:0] a);
    @(posedge clk);
    slot_cs[s] <= 1'b1;
    slot_addr[s*SLOT_AW +: SLOT_AW] <= a;
    last_addr[s] = a;
endtask

// Wait for slot_ok, then release the requester
task automatic wait_ok(input int s);
    int k;
    k = 0;
    do begin
        @(posedge clk);
        k++;
    end while (!slot_ok[s] && k < TIMEOUT);
    if (!slot_ok[s]) begin
        $display("slot %0d never returned data for address %h", s, last_addr[s]);
        tb_errors++;
    end
    slot_cs[s] <= 1'b0;
endtask

task automatic check_hit(input int s);
    logic seen;
    seen = 1'b0;
    present(s, last_addr[s]);
    @(posedge clk);
    if (!slot_ok[s]) begin
        $display("slot %0d missed on an address it had already fetched", s);
        tb_errors++;
    end
    slot_cs[s] <= 1'b0;
    // A hit must never reach the SDRAM port
    repeat (4) begin
        @(posedge clk);
        seen = seen | sdram_req;
    end
    if (seen) begin
        $display("slot %0d issued an SDRAM read on a cache hit", s);
        tb_errors++;
    end
endtask

initial begin
    seed      = SEED;
    tb_errors = 0;
    req_count = 0;
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    slot_cs   = '0;
    slot_addr = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Register access
    for (int i = 0; i < NSLOTS; i++) begin
        offs[i] = AW'($random(seed));
        apb_write(rom_pkg::REG_OFFSET_BASE + 8'(4 * i), 32'(offs[i]));
    end
    for (int i = 0; i < NSLOTS; i++) begin
        check_read(rom_pkg::REG_OFFSET_BASE + 8'(4 * i), 32'(offs[i]));
    end
    check_read(rom_pkg::REG_STATUS, 32'h0);
    apb_xfer(1'b0, 8'h08, 32'h0, rd, err);
    if (!err) begin
        $display("unmapped address 08 did not raise pslverr");
        tb_errors++;
    end

    // Random misses on every slot
    apb_write(rom_pkg::REG_CTRL, 32'h1);
    for (int r = 0; r < 3; r++) begin
        for (int i = 0; i < NSLOTS; i++) begin
            present(i, SLOT_AW'($random(seed)));
            wait_ok(i);
        end
    end

    for (int i = 0; i < NSLOTS; i++) begin
        check_hit(i);
    end

    // All slots miss together after a flush
    apb_write(rom_pkg::REG_CTRL, 32'h3);
    req_log.delete();
    @(posedge clk);
    for (int i = 0; i < NSLOTS; i++) begin
        last_addr[i] = SLOT_AW'($random(seed));
        slot_cs[i] <= 1'b1;
        slot_addr[i*SLOT_AW +: SLOT_AW] <= last_addr[i];
    end
    done = '0;
    n = 0;
    while (done != '1 && n < TIMEOUT * NSLOTS) begin
        @(posedge clk);
        done = done | slot_ok;
        n++;
    end
    slot_cs <= '0;
    if (done != '1) begin
        $display("contention run timed out, slots done %b", done);
        tb_errors++;
    end
    if (req_log.size() != NSLOTS) begin
        $display("contention run issued %0d SDRAM reads instead of %0d",
                 req_log.size(), NSLOTS);
        tb_errors++;
    end else begin
        for (int i = 0; i < NSLOTS; i++) begin
            if (req_log[i] !== offs[i] + AW'(last_addr[i])) begin
                $display("mismatch at %0t: SDRAM read %0d went to %h, expected slot %0d",
                         $time, i, req_log[i], i);
                tb_errors++;
            end
        end
    end

    // Disabled, then enabled, then flushed
    apb_write(rom_pkg::REG_CTRL, 32'h2);
    cnt = req_count;
    present(1, SLOT_AW'($random(seed)));
    n = 0;
    do begin
        apb_xfer(1'b0, rom_pkg::REG_STATUS, 32'h0, rd, err);
        n++;
    end while (!rd[1] && n < TIMEOUT);
    if (!rd[1]) begin
        $display("status bit of slot 1 never set while disabled");
        tb_errors++;
    end
    if (req_count != cnt || sdram_req) begin
        $display("SDRAM read issued while disabled");
        tb_errors++;
    end
    apb_write(rom_pkg::REG_CTRL, 32'h1);
    wait_ok(1);
    check_hit(1);
    apb_write(rom_pkg::REG_CTRL, 32'h3);
    cnt = req_count;
    present(1, last_addr[1]);
    wait_ok(1);
    if (req_count != cnt + 1) begin
        $display("flushed address on slot 1 was not fetched again");
        tb_errors++;
    end

    repeat (4) @(posedge clk);
    $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

// ==== files.f ====
+incdir+.
rom_pkg.sv
rom_cfg_regs.sv
rom_slot.sv
rom_slot_arbiter.sv
rom_fetch.sv
tb_sdram_model.sv
tb_rom_checker.sv
tb_rom_fetch.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary -j 0 --top-module tb_rom_fetch -f files.f -o tb_rom_fetch
	./obj_dir/tb_rom_fetch | tee /dev/stderr | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir
